//--- source/lcd_settings.svh
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// intervals below are in microseconds
`define LCD_CYC_PER_US   2     // clock cycles per microsecond
`define LCD_POWERUP_US   500
`define LCD_STEP_US      50    // ordinary command or data slot
`define LCD_CLEAR_US     200
`define LCD_ENTRY_US     100
`define LCD_INIT_E_US    10    // enable high during init steps
`define LCD_E_SETUP_US   1     // rs and data settle before enable
`define LCD_E_HIGH_US    13

// display geometry
`define LCD_COLS         16
`define LCD_ROW_BITS     1

`define LCD_QUEUE_DEPTH  2     // driver queue, arbiter starts with this credit

`endif

//--- source/lcd_pkg.sv
package lcd_pkg;

	typedef logic [7:0] lcd_byte_t;

	// {rs, rw, byte}, rw stays zero since reads are not supported
	typedef logic [9:0] lcd_xfer_t;

	// HD44780 instruction base codes
	typedef enum logic [7:0] {
		ins_clear = 8'h01,
		ins_home  = 8'h02,
		ins_entry = 8'h04,  // I/D and S in bits 1:0
		ins_disp  = 8'h08,  // D, C, B in bits 2:0
		ins_shift = 8'h10,  // S/C and R/L in bits 3:2
		ins_func  = 8'h30,  // 8-bit bus, N and F in bits 3:2
		ins_ddram = 8'h80   // address in bits 6:0
	} lcd_instr_e;

	typedef enum logic [1:0] {
		power_wait,
		init_seq,
		idle,
		pulse
	} drv_state_e;

	typedef enum logic [2:0] {
		func_set,
		disp_ctrl,
		disp_clear,
		entry_mode,
		done
	} init_step_e;

endpackage

//--- source/lcd_client_pkg.sv
package lcd_client_pkg;

	// who owns the transfer path
	typedef enum logic {
		cmd,
		text
	} client_e;

	typedef enum logic [2:0] {
		op_clear,
		op_home,
		op_shift_left,
		op_shift_right,
		op_display_on,
		op_display_off
	} disp_op_e;

endpackage

//--- source/lcd_driver.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_driver (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [6:0]         cfg,        // lines, font, on, cursor, blink, inc, shift
	input  logic               drv_valid,
	input  lcd_pkg::lcd_xfer_t drv_xfer,
	output logic               drv_credit,
	output logic               ready,
	output logic               lcd_e,
	output logic               lcd_rs,
	output lcd_pkg::lcd_byte_t lcd_data
);

	localparam int CYC         = `LCD_CYC_PER_US;
	localparam int POWERUP_CYC = `LCD_POWERUP_US * CYC;
	localparam int INIT_E_CYC  = `LCD_INIT_E_US * CYC;
	localparam int SETUP_CYC   = `LCD_E_SETUP_US * CYC;
	localparam int E_HIGH_CYC  = `LCD_E_HIGH_US * CYC;
	localparam int SLOT_CYC    = `LCD_STEP_US * CYC;
	localparam int CNT_W       = $clog2(POWERUP_CYC + 1);  // power-up is the longest phase
	localparam int DEPTH       = `LCD_QUEUE_DEPTH;
	localparam int PTR_W       = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	lcd_pkg::drv_state_e state;
	lcd_pkg::init_step_e step;
	lcd_pkg::init_step_e step_nxt;
	logic [CNT_W-1:0]    cnt;

	lcd_pkg::lcd_xfer_t         q_mem [DEPTH];
	logic [PTR_W-1:0]           wr_ptr;
	logic [PTR_W-1:0]           rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] q_count;
	logic                       pop;
	logic                       slot_end;

	lcd_pkg::lcd_byte_t step_byte;
	int                 step_cyc;  // enable high plus the step's wait

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// init instruction and length of the current step
	always_comb begin
		case (step)
			lcd_pkg::func_set: begin
				step_byte = lcd_pkg::ins_func | {4'b0000, cfg[6:5], 2'b00};
				step_cyc  = INIT_E_CYC + `LCD_STEP_US * CYC;
				step_nxt  = lcd_pkg::disp_ctrl;
			end
			lcd_pkg::disp_ctrl: begin
				step_byte = lcd_pkg::ins_disp | {5'b00000, cfg[4:2]};
				step_cyc  = INIT_E_CYC + `LCD_STEP_US * CYC;
				step_nxt  = lcd_pkg::disp_clear;
			end
			lcd_pkg::disp_clear: begin
				step_byte = lcd_pkg::ins_clear;
				step_cyc  = INIT_E_CYC + `LCD_CLEAR_US * CYC;
				step_nxt  = lcd_pkg::entry_mode;
			end
			lcd_pkg::entry_mode: begin
				step_byte = lcd_pkg::ins_entry | {6'b000000, cfg[1:0]};
				step_cyc  = INIT_E_CYC + `LCD_ENTRY_US * CYC;
				step_nxt  = lcd_pkg::done;
			end
			default: begin
				step_byte = '0;
				step_cyc  = INIT_E_CYC;
				step_nxt  = lcd_pkg::done;
			end
		endcase
	end

	assign slot_end = (cnt == CNT_W'(SLOT_CYC - 1));
	assign pop = (q_count != '0) &&
		((state == lcd_pkg::idle) || ((state == lcd_pkg::pulse) && slot_end));

	always_ff @(posedge clk) begin
		if (drv_valid)
			q_mem[wr_ptr] <= drv_xfer;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
		end else begin
			if (drv_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({drv_valid, pop})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= lcd_pkg::power_wait;
			step       <= lcd_pkg::func_set;
			cnt        <= '0;
			lcd_e      <= 1'b0;
			lcd_rs     <= 1'b0;
			lcd_data   <= '0;
			ready      <= 1'b0;
			drv_credit <= 1'b0;
		end else begin
			drv_credit <= pop;  // slot freed as the entry leaves
			case (state)
				lcd_pkg::power_wait: begin
					if (cnt == CNT_W'(POWERUP_CYC - 1)) begin
						cnt   <= '0;
						state <= lcd_pkg::init_seq;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				lcd_pkg::init_seq: begin
					lcd_e    <= (cnt < CNT_W'(INIT_E_CYC));
					lcd_data <= (cnt < CNT_W'(INIT_E_CYC)) ? step_byte : '0;
					if (cnt == CNT_W'(step_cyc - 1)) begin
						cnt  <= '0;
						step <= step_nxt;
						if (step == lcd_pkg::entry_mode) begin
							state <= lcd_pkg::idle;
							ready <= 1'b1;  // stays high from here on
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				lcd_pkg::idle: begin
					cnt   <= '0;
					lcd_e <= 1'b0;
					if (pop) begin
						lcd_rs   <= q_mem[rd_ptr][9];
						lcd_data <= q_mem[rd_ptr][7:0];
						state    <= lcd_pkg::pulse;
					end
				end
				default: begin  // pulse
					lcd_e <= (cnt >= CNT_W'(SETUP_CYC - 1)) &&
						(cnt < CNT_W'(SETUP_CYC + E_HIGH_CYC - 1));
					if (slot_end) begin
						cnt <= '0;
						if (pop) begin  // back to back, next slot starts now
							lcd_rs   <= q_mem[rd_ptr][9];
							lcd_data <= q_mem[rd_ptr][7:0];
						end else begin
							lcd_rs   <= 1'b0;
							lcd_data <= '0;
							state    <= lcd_pkg::idle;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// arbiter credit must keep the queue from overflowing
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		drv_valid |-> (q_count < DEPTH))
		else $error("transfer pushed into a full driver queue");

	a_e_after_powerup: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_e |-> (state != lcd_pkg::power_wait))
		else $error("lcd_e high during power-up wait");

endmodule

//--- source/lcd_arbiter.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_arbiter (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cmd_xfer_valid,
	input  lcd_pkg::lcd_xfer_t cmd_xfer,
	input  logic               text_xfer_valid,
	input  lcd_pkg::lcd_xfer_t text_xfer,
	output logic               cmd_credit,
	output logic               text_credit,
	output logic               drv_valid,
	output lcd_pkg::lcd_xfer_t drv_xfer,
	input  logic               drv_credit
);

	localparam int CRED_W = $clog2(`LCD_QUEUE_DEPTH + 1);

	logic                    cmd_full;
	logic                    text_full;
	lcd_pkg::lcd_xfer_t      cmd_slot;
	lcd_pkg::lcd_xfer_t      text_slot;
	lcd_client_pkg::client_e last_grant;
	logic [CRED_W-1:0]       drv_cred;  // free driver queue entries
	logic                    grant_cmd;
	logic                    grant_text;

	always_comb begin
		grant_cmd  = 1'b0;
		grant_text = 1'b0;
		if (drv_cred != '0) begin
			if (cmd_full && text_full) begin  // take whoever lost last time
				grant_cmd  = (last_grant == lcd_client_pkg::text);
				grant_text = (last_grant == lcd_client_pkg::cmd);
			end else begin
				grant_cmd  = cmd_full;
				grant_text = text_full;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_xfer_valid)
			cmd_slot <= cmd_xfer;
		if (text_xfer_valid)
			text_slot <= text_xfer;
		if (grant_cmd)
			drv_xfer <= cmd_slot;
		else if (grant_text)
			drv_xfer <= text_slot;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_full    <= 1'b0;
			text_full   <= 1'b0;
			last_grant  <= lcd_client_pkg::text;  // cmd wins the first tie
			drv_cred    <= CRED_W'(`LCD_QUEUE_DEPTH);
			drv_valid   <= 1'b0;
			cmd_credit  <= 1'b0;
			text_credit <= 1'b0;
		end else begin
			cmd_full    <= cmd_xfer_valid || (cmd_full && !grant_cmd);
			text_full   <= text_xfer_valid || (text_full && !grant_text);
			drv_valid   <= grant_cmd || grant_text;
			cmd_credit  <= grant_cmd;
			text_credit <= grant_text;
			if (grant_cmd)
				last_grant <= lcd_client_pkg::cmd;
			else if (grant_text)
				last_grant <= lcd_client_pkg::text;
			case ({grant_cmd || grant_text, drv_credit})
				2'b10:   drv_cred <= drv_cred - 1'b1;
				2'b01:   drv_cred <= drv_cred + 1'b1;
				default: drv_cred <= drv_cred;
			endcase
		end
	end

	// client credit counters keep each slot single-occupancy
	a_cmd_slot: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_xfer_valid |-> !cmd_full)
		else $error("cmd client wrote a full slot");

	a_text_slot: assert property (@(posedge clk) disable iff (!rst_n)
		text_xfer_valid |-> !text_full)
		else $error("text client wrote a full slot");

endmodule

//--- source/lcd_cmd_issuer.sv
`timescale 1ns/10ps

module lcd_cmd_issuer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     op_valid,
	input  lcd_client_pkg::disp_op_e op,
	output logic                     op_credit,
	output logic                     cmd_xfer_valid,
	output lcd_pkg::lcd_xfer_t       cmd_xfer,
	input  logic                     cmd_credit,
	output logic                     cursor_lost
);

	lcd_client_pkg::disp_op_e op_q;
	logic                     op_full;
	logic                     cred;  // one arbiter slot
	logic                     post;

	function automatic lcd_pkg::lcd_byte_t encode_op(input lcd_client_pkg::disp_op_e o);
		case (o)
			lcd_client_pkg::op_clear:       return lcd_pkg::ins_clear;
			lcd_client_pkg::op_home:        return lcd_pkg::ins_home;
			lcd_client_pkg::op_shift_left:  return lcd_pkg::ins_shift | 8'h08;
			lcd_client_pkg::op_shift_right: return lcd_pkg::ins_shift | 8'h0C;
			lcd_client_pkg::op_display_on:  return lcd_pkg::ins_disp | 8'h04;
			default:                        return lcd_pkg::ins_disp;  // display off
		endcase
	endfunction

	assign post = op_full && cred;

	always_ff @(posedge clk) begin
		if (op_valid)
			op_q <= op;
		if (post)
			cmd_xfer <= {1'b0, 1'b0, encode_op(op_q)};  // rs low
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_full        <= 1'b0;
			cred           <= 1'b1;
			cmd_xfer_valid <= 1'b0;
			op_credit      <= 1'b0;
			cursor_lost    <= 1'b0;
		end else begin
			op_full        <= op_valid || (op_full && !post);
			cred           <= (cred && !post) || cmd_credit;
			cmd_xfer_valid <= post;
			op_credit      <= post;
			cursor_lost    <= post && (op_q inside {lcd_client_pkg::op_clear,
				lcd_client_pkg::op_home, lcd_client_pkg::op_shift_left,
				lcd_client_pkg::op_shift_right});
		end
	end

endmodule

//--- source/lcd_text_writer.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_text_writer (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           char_valid,
	input  lcd_pkg::lcd_byte_t             char_code,
	input  logic [`LCD_ROW_BITS-1:0]       row,
	input  logic [$clog2(`LCD_COLS)-1:0]   col,
	output logic                           char_credit,
	output logic                           text_xfer_valid,
	output lcd_pkg::lcd_xfer_t             text_xfer,
	input  logic                           text_credit,
	input  logic                           cursor_lost
);

	localparam int COL_W = $clog2(`LCD_COLS);

	lcd_pkg::lcd_byte_t        char_q;
	logic [`LCD_ROW_BITS-1:0]  row_q;
	logic [COL_W-1:0]          col_q;
	logic [`LCD_ROW_BITS-1:0]  exp_row;  // where the display cursor should be
	logic [COL_W-1:0]          exp_col;
	logic                      pos_valid;
	logic                      char_full;
	logic                      addr_sent;
	logic                      cred;
	logic                      at_cursor;
	logic                      post_addr;
	logic                      post_data;
	lcd_pkg::lcd_byte_t        addr_byte;

	assign at_cursor = pos_valid && (row_q == exp_row) && (col_q == exp_col);
	assign post_addr = char_full && cred && !addr_sent && !at_cursor;
	assign post_data = char_full && cred && (addr_sent || at_cursor);
	assign addr_byte = lcd_pkg::ins_ddram + lcd_pkg::lcd_byte_t'(row_q) * 8'h40 +
		lcd_pkg::lcd_byte_t'(col_q);

	always_ff @(posedge clk) begin
		if (char_valid) begin
			char_q <= char_code;
			row_q  <= row;
			col_q  <= col;
		end
		if (post_addr)
			text_xfer <= {1'b0, 1'b0, addr_byte};  // set DDRAM address
		else if (post_data)
			text_xfer <= {1'b1, 1'b0, char_q};
		if (post_data) begin
			exp_row <= row_q;
			exp_col <= col_q + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			char_full       <= 1'b0;
			addr_sent       <= 1'b0;
			pos_valid       <= 1'b0;
			cred            <= 1'b1;
			text_xfer_valid <= 1'b0;
			char_credit     <= 1'b0;
		end else begin
			char_full       <= char_valid || (char_full && !post_data);
			addr_sent       <= (addr_sent || post_addr) && !post_data;
			cred            <= (cred && !(post_addr || post_data)) || text_credit;
			text_xfer_valid <= post_addr || post_data;
			char_credit     <= post_data;  // data byte is the last word
			if (cursor_lost)
				pos_valid <= 1'b0;
			else if (post_data)
				pos_valid <= (col_q != COL_W'(`LCD_COLS - 1));  // off the row end
		end
	end

	// a credit arriving while one is held would allow a post into a full slot
	a_post_credit: assert property (@(posedge clk) disable iff (!rst_n)
		text_credit |-> !cred)
		else $error("text credit returned with no post outstanding");

endmodule

//--- source/lcd_top.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcd_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [6:0]                   cfg,
	input  logic                         op_valid,
	input  lcd_client_pkg::disp_op_e     op,
	input  logic                         char_valid,
	input  lcd_pkg::lcd_byte_t           char_code,
	input  logic [`LCD_ROW_BITS-1:0]     row,
	input  logic [$clog2(`LCD_COLS)-1:0] col,
	output logic                         lcd_e,
	output logic                         lcd_rs,
	output lcd_pkg::lcd_byte_t           lcd_data,
	output logic                         ready,
	output logic                         op_credit,
	output logic                         char_credit
);

	logic               cmd_xfer_valid;
	lcd_pkg::lcd_xfer_t cmd_xfer;
	logic               cmd_credit;
	logic               text_xfer_valid;
	lcd_pkg::lcd_xfer_t text_xfer;
	logic               text_credit;
	logic               drv_valid;
	lcd_pkg::lcd_xfer_t drv_xfer;
	logic               drv_credit;
	logic               cursor_lost;  // cmd moved the cursor

	lcd_cmd_issuer u_cmd (.clk, .rst_n, .op_valid, .op, .op_credit,
		.cmd_xfer_valid, .cmd_xfer, .cmd_credit, .cursor_lost);

	lcd_text_writer u_text (.clk, .rst_n, .char_valid, .char_code, .row, .col,
		.char_credit, .text_xfer_valid, .text_xfer, .text_credit, .cursor_lost);

	lcd_arbiter u_arb (.clk, .rst_n, .cmd_xfer_valid, .cmd_xfer, .text_xfer_valid,
		.text_xfer, .cmd_credit, .text_credit, .drv_valid, .drv_xfer, .drv_credit);

	lcd_driver u_drv (.clk, .rst_n, .cfg, .drv_valid, .drv_xfer, .drv_credit,
		.ready, .lcd_e, .lcd_rs, .lcd_data);

endmodule

//--- testbench/tb_lcd_top.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module tb_lcd_top;

	localparam int K_OP    = 0;
	localparam int K_CHAR  = 1;
	localparam int K_PAIR  = 2;
	localparam int COL_W   = $clog2(`LCD_COLS);
	localparam int INIT_US = 4 * `LCD_INIT_E_US + 2 * `LCD_STEP_US + `LCD_CLEAR_US +
		`LCD_ENTRY_US;

	typedef struct {
		int                          kind;
		lcd_client_pkg::disp_op_e    op;
		lcd_pkg::lcd_byte_t          code;  // zero draws a pad character
		logic [`LCD_ROW_BITS-1:0]    row;
		logic [COL_W-1:0]            col;
	} entry_t;

	logic                     clk;
	logic                     rst_n;
	logic [6:0]               cfg;
	logic                     op_valid;
	lcd_client_pkg::disp_op_e op;
	logic                     char_valid;
	lcd_pkg::lcd_byte_t       char_code;
	logic [`LCD_ROW_BITS-1:0] row;
	logic [COL_W-1:0]         col;
	logic                     lcd_e;
	logic                     lcd_rs;
	lcd_pkg::lcd_byte_t       lcd_data;
	logic                     ready;
	logic                     op_credit;
	logic                     char_credit;

	entry_t                   table_q[$];
	lcd_pkg::lcd_xfer_t       exp_q[$];       // expected bus words in order
	lcd_pkg::lcd_xfer_t       text_words[$];
	lcd_client_pkg::client_e  last_src;       // source of the last granted word
	logic [15:0]              lfsr;
	logic                     ref_valid;      // cursor model
	logic [`LCD_ROW_BITS-1:0] ref_row;
	logic [COL_W-1:0]         ref_col;
	logic                     e_was = 1'b0;
	logic                     cap_rs;
	lcd_pkg::lcd_byte_t       cap_data;
	int op_cnt, char_cnt, n_seen, n_checks, n_value_err, n_other_err;
	int cycles = 0;
	int limit = 0;

	lcd_top dut (.clk, .rst_n, .cfg, .op_valid, .op, .char_valid, .char_code, .row, .col,
		.lcd_e, .lcd_rs, .lcd_data, .ready, .op_credit, .char_credit);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function int draw_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// instruction bytes of the display operations
	function automatic lcd_pkg::lcd_byte_t op_byte(input lcd_client_pkg::disp_op_e o);
		case (o)
			lcd_client_pkg::op_clear:       return 8'h01;
			lcd_client_pkg::op_home:        return 8'h02;
			lcd_client_pkg::op_shift_left:  return 8'h18;
			lcd_client_pkg::op_shift_right: return 8'h1C;
			lcd_client_pkg::op_display_on:  return 8'h0C;
			lcd_client_pkg::op_display_off: return 8'h08;
			default:                        return 8'h00;
		endcase
	endfunction

	task other_fail(input string msg);
		n_other_err++;
		$display("%0t ns: %s", $time, msg);
	endtask

	task check_xfer(input lcd_pkg::lcd_xfer_t got, input lcd_pkg::lcd_xfer_t exp,
		input string what);
		n_checks++;
		if (got !== exp) begin
			n_value_err++;
			$display("ERROR %0t ns: %s got rs=%b data=0x%h, expected rs=%b data=0x%h",
				$time, what, got[9], got[7:0], exp[9], exp[7:0]);
		end
	endtask

	task check_flag(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_value_err++;
			$display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task add_op(input lcd_client_pkg::disp_op_e o);
		table_q.push_back(entry_t'{K_OP, o, 8'h00, 1'b0, '0});
	endtask

	task add_char(input lcd_pkg::lcd_byte_t code, input logic r, input logic [COL_W-1:0] c);
		table_q.push_back(entry_t'{K_CHAR, lcd_client_pkg::op_clear, code, r, c});
	endtask

	task add_pair(input lcd_client_pkg::disp_op_e o, input lcd_pkg::lcd_byte_t code,
		input logic r, input logic [COL_W-1:0] c);
		table_q.push_back(entry_t'{K_PAIR, o, code, r, c});
	endtask

	task push_word(input lcd_pkg::lcd_xfer_t w, input lcd_client_pkg::client_e src);
		exp_q.push_back(w);
		last_src = src;
	endtask

	// words for one character, address only when the cursor is elsewhere
	task build_text(input logic r, input logic [COL_W-1:0] c, input lcd_pkg::lcd_byte_t code);
		text_words.delete();
		if (!(ref_valid && r == ref_row && c == ref_col))
			text_words.push_back({2'b00, 8'h80 + ((r != 0) ? 8'h40 : 8'h00) + 8'(c)});
		text_words.push_back({2'b10, code});
		ref_row   = r;
		ref_col   = c + 1'b1;
		ref_valid = (c != COL_W'(`LCD_COLS - 1));
	endtask

	// one falling edge, valids drop and returned credits are counted
	task next_cycle();
		@(negedge clk);
		op_valid   = 1'b0;
		char_valid = 1'b0;
		if (op_credit) begin
			if (op_cnt != 0)
				other_fail("op_credit pulsed with no operation outstanding");
			else
				op_cnt++;
		end
		if (char_credit) begin
			if (char_cnt != 0)
				other_fail("char_credit pulsed with no character outstanding");
			else
				char_cnt++;
		end
	endtask

	// bus monitor, word taken at the last sample before lcd_e falls
	always @(negedge clk) begin
		if (lcd_e) begin
			cap_rs   = lcd_rs;
			cap_data = lcd_data;
			e_was    = 1'b1;
		end else if (e_was) begin
			e_was = 1'b0;
			if (exp_q.size() == 0)
				other_fail($sformatf("unexpected transfer rs=%b data=0x%h", cap_rs, cap_data));
			else
				check_xfer({cap_rs, 1'b0, cap_data}, exp_q.pop_front(),
					$sformatf("transfer %0d", n_seen));
			check_flag(ready, n_seen >= 4, "ready at end of transfer");
			n_seen++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, the display bus stopped making progress", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin
		entry_t             e;
		lcd_pkg::lcd_byte_t code;
		lcd_pkg::lcd_xfer_t cmd_word;
		int                 prev_kind;
		int                 gap;
		rst_n       = 1'b0;
		cfg         = 7'b1011010;  // 2 lines, 5x8, on, cursor, no blink, increment
		op_valid    = 1'b0;
		op          = lcd_client_pkg::op_clear;
		char_valid  = 1'b0;
		char_code   = 8'h00;
		row         = '0;
		col         = '0;
		lfsr        = 16'd52914;
		last_src    = lcd_client_pkg::text;  // cmd wins the first tie
		ref_valid   = 1'b0;
		ref_row     = '0;
		ref_col     = '0;
		op_cnt      = 1;
		char_cnt    = 1;
		n_seen      = 0;
		n_checks    = 0;
		n_value_err = 0;
		n_other_err = 0;
		prev_kind   = K_OP;
		add_op(lcd_client_pkg::op_display_on);
		add_char(8'h48, 1'b0, 4'd0);
		add_char(8'h00, 1'b0, 4'd1);
		add_char(8'h00, 1'b0, 4'd2);
		add_char(8'h00, 1'b1, 4'd5);  // row jump
		add_op(lcd_client_pkg::op_clear);
		add_char(8'h00, 1'b1, 4'd6);
		add_pair(lcd_client_pkg::op_display_off, 8'h00, 1'b1, 4'd7);
		add_op(lcd_client_pkg::op_shift_right);
		add_pair(lcd_client_pkg::op_display_on, 8'h5A, 1'b0, 4'd15);
		add_char(8'h00, 1'b1, 4'd0);
		add_op(lcd_client_pkg::op_home);
		add_op(lcd_client_pkg::op_shift_left);
		for (int c = 3; c < 9; c++)
			add_char(8'h00, 1'b0, COL_W'(c));  // burst along row 0
		add_pair(lcd_client_pkg::op_display_off, 8'h00, 1'b0, 4'd9);
		add_op(lcd_client_pkg::op_display_on);
		add_pair(lcd_client_pkg::op_display_off, 8'h00, 1'b0, 4'd10);
		limit = 2 * (`LCD_POWERUP_US + INIT_US + 110 * table_q.size()) * `LCD_CYC_PER_US + 2000;

		// init sequence built from the cfg fields
		exp_q.push_back({2'b00, 4'h3, cfg[6], cfg[5], 2'b00});
		exp_q.push_back({2'b00, 5'b00001, cfg[4], cfg[3], cfg[2]});
		exp_q.push_back({2'b00, 8'h01});
		exp_q.push_back({2'b00, 6'b000001, cfg[1], cfg[0]});
		repeat (5) next_cycle();
		rst_n = 1'b1;
		check_flag(ready, 1'b0, "ready after reset");
		while (!ready)
			next_cycle();
		if (n_seen != 4)
			other_fail("ready rose before all four init instructions were sent");

		foreach (table_q[i]) begin
			e = table_q[i];
			if (!(e.kind == K_CHAR && prev_kind == K_CHAR)) begin
				while (exp_q.size() != 0)
					next_cycle();  // let the bus go quiet
			end
			gap = draw_bits(3);
			repeat (gap) next_cycle();
			code = (e.code != 8'h00) ? e.code : 8'h30 + 8'(draw_bits(6));
			while ((e.kind != K_CHAR && op_cnt == 0) || (e.kind != K_OP && char_cnt == 0))
				next_cycle();
			cmd_word = {2'b00, op_byte(e.op)};
			if (e.kind != K_OP)
				build_text(e.row, e.col, code);
			if (e.kind == K_OP) begin
				push_word(cmd_word, lcd_client_pkg::cmd);
				if (e.op inside {lcd_client_pkg::op_clear, lcd_client_pkg::op_home,
					lcd_client_pkg::op_shift_left, lcd_client_pkg::op_shift_right})
					ref_valid = 1'b0;
			end else if (e.kind == K_CHAR) begin
				foreach (text_words[k])
					push_word(text_words[k], lcd_client_pkg::text);
			end else if (last_src == lcd_client_pkg::text) begin  // cmd takes the tie
				push_word(cmd_word, lcd_client_pkg::cmd);
				foreach (text_words[k])
					push_word(text_words[k], lcd_client_pkg::text);
			end else begin
				push_word(text_words[0], lcd_client_pkg::text);
				push_word(cmd_word, lcd_client_pkg::cmd);
				for (int k = 1; k < text_words.size(); k++)
					push_word(text_words[k], lcd_client_pkg::text);
			end
			if (e.kind != K_CHAR) begin
				op_valid = 1'b1;
				op       = e.op;
				op_cnt--;
			end
			if (e.kind != K_OP) begin
				char_valid = 1'b1;
				char_code  = code;
				row        = e.row;
				col        = e.col;
				char_cnt--;
			end
			next_cycle();
			prev_kind = e.kind;
		end

		while (exp_q.size() != 0)
			next_cycle();
		repeat (4 * `LCD_STEP_US * `LCD_CYC_PER_US) next_cycle();  // catch late duplicates
		if (op_cnt != 1 || char_cnt != 1)
			other_fail("an input credit was never returned");
		$display("checks %0d, value errors %0d, other errors %0d",
			n_checks, n_value_err, n_other_err);
		if (n_value_err == 0 && n_other_err == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- sim.f
+incdir+source
source/lcd_pkg.sv
source/lcd_client_pkg.sv
source/lcd_driver.sv
source/lcd_arbiter.sv
source/lcd_cmd_issuer.sv
source/lcd_text_writer.sv
source/lcd_top.sv
testbench/tb_lcd_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_lcd_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
